// File: Bender.yml
package:
  name: zports

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/zports_bus_pkg.sv
      - hdl/zports_cfg_pkg.sv
      - hdl/io_strobe_sync.sv
      - hdl/port_decode.sv
      - hdl/spectrum_ports.sv
      - hdl/evo_config.sv
      - hdl/ulaplus_ports.sv
      - hdl/port_readback.sv
      - hdl/zports_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/zports_checker.sv
      - verification/zports_tb.sv

// File: hdl/evo_config.sv
// evo configuration ports
// BF config register, BD breakpoint address, BE clear-nmi

module evo_config import zports_bus_pkg::*, zports_cfg_pkg::*; (
	input  logic        fclk,
	input  logic        rst_n,
	input  zbus_t       bus,
	input  port_sel_t   sel,
	input  logic        dos,
	output evo_cfg_t    cfg,
	output logic        shadow,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        brk_ena,
	output logic [15:0] brk_addr,
	output logic        clr_nmi
);

	////////////////////
	// BF write, din[2] font enable dropped
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			cfg <= '0;
		else if (sel.bf_wr)
		begin
			cfg.shadow_en <= bus.din[0];
			cfg.romrw_en  <= bus.din[1];
			cfg.set_nmi   <= bus.din[3];
			cfg.brk_ena   <= bus.din[4];
		end
	end

	// BD write, a[8] picks the byte
	always_ff @(posedge fclk)
	begin
		if (sel.bd_wr)
		begin
			if (bus.a[8])
				brk_addr[15:8] <= bus.din;
			else
				brk_addr[7:0] <= bus.din;
		end
	end

	assign shadow   = dos | cfg.shadow_en;
	assign romrw_en = cfg.romrw_en;
	assign set_nmi  = cfg.set_nmi;
	assign brk_ena  = cfg.brk_ena;
	assign clr_nmi  = sel.be_wr; // any BE write ends nmi

endmodule

// File: hdl/io_strobe_sync.sv
// Z80 io cycle to fclk strobe converter
// one port_wr or port_rd pulse per io cycle

module io_strobe_sync import zports_bus_pkg::*; (
	input  logic    fclk,
	input  logic    rst_n,
	input  logic    zpos,    // z80 clock rising phase
	input  zbus_t   bus,
	output strobe_t strobes
);

	logic       wr_act, rd_act; // cycle active levels
	logic [1:0] wr_sh, rd_sh;   // [0] zpos sample, [1] delayed

	assign wr_act = ~(bus.iorq_n | bus.wr_n);
	assign rd_act = ~(bus.iorq_n | bus.rd_n);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_sh   <= 2'b00;
			rd_sh   <= 2'b00;
			strobes <= '0;
		end
		else
		begin
			if (zpos)
			begin
				wr_sh[0] <= wr_act;
				rd_sh[0] <= rd_act;
			end
			wr_sh[1] <= wr_sh[0]; // plain fclk delay
			rd_sh[1] <= rd_sh[0];
			strobes.port_wr <= wr_sh[0] & ~wr_sh[1]; // rising edge only
			strobes.port_rd <= rd_sh[0] & ~rd_sh[1];
		end
	end

endmodule

// File: hdl/port_decode.sv
// port address decoder
// port hit, external port, AY control and gated write selects

`include "zports_consts.svh"

module port_decode import zports_bus_pkg::*; (
	input  zbus_t     bus,
	input  strobe_t   strobes,
	input  logic      shadow,        // dos or shadow_en
	output port_sel_t sel,
	output logic      porthit,
	output logic      external_port, // AY goes to the outside
	output logic      dataout,
	output logic      ay_bc1,
	output logic      ay_bdir
);

	logic [7:0] loa;
	logic       hit_fe, hit_fd, hit_f7, hit_bf, hit_be, hit_bd, hit_up;
	logic       io_cyc;

	assign loa = bus.a[7:0];

	////////////////////
	// port compares
	assign hit_fe = (loa == `ZPORT_FE) || (loa == `ZPORT_F6);
	assign hit_fd = (loa == `ZPORT_FD);
	assign hit_f7 = (loa == `ZPORT_F7) && !shadow; // EFF7 gone in shadow
	assign hit_bf = (loa == `ZPORT_BF);
	assign hit_be = (loa == `ZPORT_BE);
	assign hit_bd = (loa == `ZPORT_BD);
	assign hit_up = (loa == `ZPORT_ULAPLUS);

	assign porthit = hit_fe | hit_fd | hit_f7 | hit_bf | hit_be | hit_bd | hit_up;

	// BFFD / FFFD
	assign external_port = hit_fd & bus.a[15];

	// drive z80 data bus on internal reads only
	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n & ~external_port;

	////////////////////
	// AY control
	assign io_cyc  = ~bus.iorq_n & (~bus.rd_n | ~bus.wr_n);
	assign ay_bc1  = hit_fd & (bus.a[15:14] == 2'b11) & io_cyc; // FFFD addr / read
	assign ay_bdir = hit_fd & bus.a[15] & ~bus.iorq_n & ~bus.wr_n;

	////////////////////
	// write selects, one fclk each
	always_comb
	begin
		sel            = '0;
		sel.fe_wr      = hit_fe & strobes.port_wr;
		sel.fd7_wr     = hit_fd & strobes.port_wr;   // a[15] checked at the register
		sel.eff7_wr    = hit_f7 & bus.a[8] & strobes.port_wr;
		sel.bf_wr      = hit_bf & strobes.port_wr;
		sel.bd_wr      = hit_bd & strobes.port_wr;
		sel.be_wr      = hit_be & strobes.port_wr;  // nmi end
		sel.up_cmd_wr  = hit_up & ~bus.a[14] & strobes.port_wr; // BF3B
		sel.up_data_wr = hit_up &  bus.a[14] & strobes.port_wr; // FF3B
	end

endmodule

// File: hdl/port_readback.sv
// port read data mux
// FE/F6 keyboard, BF config and BE indexed readback

`include "zports_consts.svh"

module port_readback import zports_bus_pkg::*, zports_cfg_pkg::*; (
	input  zbus_t       bus,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  page_regs_t  regs,
	input  evo_cfg_t    cfg,
	input  logic [15:0] brk_addr,
	output logic [7:0]  dout
);

	logic [7:0] bemux;

	////////////////////
	// BE readback by a[12:8]
	always_comb
	begin
		case (bus.a[12:8])
			`BE_IDX_P7FFD: bemux = regs.p7ffd; // raw, not masked
			`BE_IDX_PEFF7: bemux = regs.peff7;
			`BE_IDX_BRKLO: bemux = brk_addr[7:0];
			`BE_IDX_BRKHI: bemux = brk_addr[15:8];
			default:       bemux = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (bus.a[7:0])
			`ZPORT_FE, `ZPORT_F6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			`ZPORT_BF:
				dout = {3'b000, cfg.brk_ena, cfg.set_nmi, 1'b0, cfg.romrw_en, cfg.shadow_en};
			`ZPORT_BE:
				dout = bemux;
			default:
				dout = 8'hFF; // idle bus
		endcase
	end

endmodule

// File: hdl/spectrum_ports.sv
// spectrum ports: FE border, 7FFD and EFF7 paging
// masked paging and pentagon 1M page outputs

`include "zports_consts.svh"

module spectrum_ports import zports_bus_pkg::*, zports_cfg_pkg::*; (
	input  logic       fclk,
	input  logic       rst_n,
	input  zbus_t      bus,
	input  port_sel_t  sel,
	output page_regs_t regs,        // raw values for readback
	output logic [3:0] border,
	output logic       beeper_wr,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	logic [7:0] p7ffd_int, peff7_int;
	logic       block1m, block7ffd;

	assign block1m   = peff7_int[`EFF7_BLOCK1M];
	assign block7ffd = p7ffd_int[`P7FFD_LOCK] & block1m; // 128k lock only without 1M

	////////////////////
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border    <= `BORDER_RST;
			p7ffd_int <= `P7FFD_RST;
			peff7_int <= `PEFF7_RST;
		end
		else
		begin
			if (sel.fe_wr)
				border <= {~bus.a[3], bus.din[2:0]}; // bright from a[3]
			if (sel.fd7_wr && !bus.a[15] && !block7ffd)
				p7ffd_int <= bus.din;
			if (sel.eff7_wr && !bus.a[12])
				peff7_int <= bus.din;
		end
	end

	assign beeper_wr = sel.fe_wr;

	assign regs.p7ffd = p7ffd_int;
	assign regs.peff7 = peff7_int;

	// high page bits hidden in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};
	assign peff7 = block1m ? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
		: peff7_int;

	assign pent1m_page   = {p7ffd_int[7:5], p7ffd_int[2:0]};
	assign pent1m_rom    = p7ffd_int[`P7FFD_ROM];
	assign pent1m_1m_on  = ~block1m;
	assign pent1m_ram0_0 = peff7_int[`EFF7_RAM0];

endmodule

// File: hdl/ulaplus_ports.sv
// ULAplus ports
// BF3B command and FF3B data, palette write and enable

`include "zports_consts.svh"

module ulaplus_ports import zports_bus_pkg::*, zports_cfg_pkg::*; (
	input  logic       fclk,
	input  logic       rst_n,
	input  zbus_t      bus,
	input  port_sel_t  sel,
	output logic       up_ena,
	output logic [5:0] up_paladdr,
	output logic [7:0] up_paldata,
	output logic       up_palwr
);

	ulaplus_byte_u up_byte;
	logic          up_select; // 1 = mode group, 0 = palette

	assign up_byte = bus.din;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			up_select <= 1'b0;
			up_ena    <= 1'b0;
		end
		else
		begin
			if (sel.up_cmd_wr && up_byte.cmd.mode == `UP_MODE_GRP)
				up_select <= 1'b1;
			if (sel.up_cmd_wr && up_byte.cmd.mode == `UP_MODE_PAL)
				up_select <= 1'b0;
			if (sel.up_data_wr && up_select)
				up_ena <= up_byte[0]; // ulaplus on/off
		end
	end

	// palette address, payload only
	always_ff @(posedge fclk)
	begin
		if (sel.up_cmd_wr && up_byte.cmd.mode == `UP_MODE_PAL)
			up_paladdr <= up_byte.cmd.paladdr;
	end

	assign up_palwr   = sel.up_data_wr & ~up_select;
	assign up_paldata = {up_byte.col.r, up_byte.col.g, up_byte.col.b}; // G3R3B2 to R3G3B2

endmodule

// File: hdl/zports_bus_pkg.sv
// Z80 bus and internal strobe types
// the bus as sampled, io strobes and per-port write selects

package zports_bus_pkg;

	// z80 bus, 27 bits
	typedef struct packed {
		logic [15:0] a;
		logic [7:0]  din;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} zbus_t;

	// one-cycle fclk strobes
	typedef struct packed {
		logic port_wr;
		logic port_rd;
	} strobe_t;

	// one-cycle write selects
	typedef struct packed {
		logic fe_wr;      // FE / F6
		logic fd7_wr;     // 7FFD
		logic eff7_wr;
		logic bf_wr;
		logic bd_wr;
		logic be_wr;
		logic up_cmd_wr;  // BF3B
		logic up_data_wr; // FF3B
	} port_sel_t;

endpackage

// File: hdl/zports_cfg_pkg.sv
// register content types
// BF config, paging registers and the ULAplus byte decode

package zports_cfg_pkg;

	// BF register, font bit not kept
	typedef struct packed {
		logic brk_ena;   // din[4]
		logic set_nmi;   // din[3]
		logic romrw_en;  // din[1]
		logic shadow_en; // din[0]
	} evo_cfg_t;

	// raw paging registers, unmasked
	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] peff7;
	} page_regs_t;

	////////////////////
	// ulaplus byte as command
	typedef struct packed {
		logic [1:0] mode;    // 00 palette addr, 01 group
		logic [5:0] paladdr;
	} up_cmd_t;

	// same byte as colour data
	typedef struct packed {
		logic [2:0] g;
		logic [2:0] r;
		logic [1:0] b;
	} up_col_t;

	// one din byte, two readings
	typedef union packed {
		up_cmd_t cmd;
		up_col_t col;
	} ulaplus_byte_u;

endpackage

// File: hdl/zports_consts.svh
// I/O port block constants
// port numbers, register bit positions and reset values

`ifndef ZPORTS_CONSTS_SVH
`define ZPORTS_CONSTS_SVH

////////////////////
// low address bytes of the kept ports
`define ZPORT_FE      8'hFE  // border, beeper, keyboard
`define ZPORT_F6      8'hF6  // FE alias
`define ZPORT_FD      8'hFD  // 7FFD paging and AY
`define ZPORT_F7      8'hF7  // EFF7
`define ZPORT_BF      8'hBF  // evo config
`define ZPORT_BE      8'hBE  // config readback, nmi end
`define ZPORT_BD      8'hBD  // breakpoint address
`define ZPORT_ULAPLUS 8'h3B  // BF3B cmd, FF3B data

////////////////////
// BE readback indexes, a[12:8]
`define BE_IDX_P7FFD  5'h0A
`define BE_IDX_PEFF7  5'h0B
`define BE_IDX_BRKLO  5'h10
`define BE_IDX_BRKHI  5'h11

////////////////////
// register bit positions
`define EFF7_BLOCK1M  2  // 1 disables pent 1M
`define EFF7_RAM0     3
`define P7FFD_ROM     4
`define P7FFD_LOCK    5  // 128k lock

// ulaplus command modes, din[7:6]
`define UP_MODE_PAL   2'b00  // palette address
`define UP_MODE_GRP   2'b01  // mode group select

// reset values
`define P7FFD_RST     8'h00
`define PEFF7_RST     8'h00
`define BORDER_RST    4'h0

`endif

// File: hdl/zports_top.sv
// Z80 io port block, top level
// strobe sync, decode, register blocks and readback mux

module zports_top import zports_bus_pkg::*, zports_cfg_pkg::*; (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        zpos,
	input  zbus_t       bus,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic        external_port,
	output logic        ay_bc1,
	output logic        ay_bdir,
	output logic [3:0]  border,
	output logic        beeper_wr,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        brk_ena,
	output logic [15:0] brk_addr,
	output logic        clr_nmi,
	output logic        up_ena,
	output logic [5:0]  up_paladdr,
	output logic [7:0]  up_paldata,
	output logic        up_palwr
);

	strobe_t    strobes;
	port_sel_t  sel;
	page_regs_t regs;
	evo_cfg_t   cfg;
	logic       shadow;

	////////////////////
	io_strobe_sync u_sync (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.zpos    (zpos),
		.bus     (bus),
		.strobes (strobes)
	);

	port_decode u_decode (
		.bus           (bus),
		.strobes       (strobes),
		.shadow        (shadow),
		.sel           (sel),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout),
		.ay_bc1        (ay_bc1),
		.ay_bdir       (ay_bdir)
	);

	////////////////////
	// register blocks
	spectrum_ports u_spec (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.bus           (bus),
		.sel           (sel),
		.regs          (regs),
		.border        (border),
		.beeper_wr     (beeper_wr),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	evo_config u_cfg (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.bus      (bus),
		.sel      (sel),
		.dos      (dos),
		.cfg      (cfg),
		.shadow   (shadow),  // back to decode
		.romrw_en (romrw_en),
		.set_nmi  (set_nmi),
		.brk_ena  (brk_ena),
		.brk_addr (brk_addr),
		.clr_nmi  (clr_nmi)
	);

	ulaplus_ports u_ulaplus (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.bus        (bus),
		.sel        (sel),
		.up_ena     (up_ena),
		.up_paladdr (up_paladdr),
		.up_paldata (up_paldata),
		.up_palwr   (up_palwr)
	);

	port_readback u_readback (
		.bus       (bus),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.regs      (regs),
		.cfg       (cfg),
		.brk_addr  (brk_addr),
		.dout      (dout)
	);

endmodule

// File: sim.f
+incdir+hdl
hdl/zports_bus_pkg.sv
hdl/zports_cfg_pkg.sv
hdl/io_strobe_sync.sv
hdl/port_decode.sv
hdl/spectrum_ports.sv
hdl/evo_config.sv
hdl/ulaplus_ports.sv
hdl/port_readback.sv
hdl/zports_top.sv
verification/zports_checker.sv
verification/zports_tb.sv

// File: verification/zports_checker.sv
// io port block protocol checks
// strobe width, strobe exclusion, data drive and palette write

module zports_checker import zports_bus_pkg::*; (
	input logic    fclk,
	input logic    rst_n,
	input strobe_t strobes,
	input logic    dataout,
	input logic    external_port,
	input logic    up_palwr,
	input logic    iorq_n
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////
	// strobes are single fclk pulses
	wr_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		strobes.port_wr |=> !strobes.port_wr)
		else $error("port_wr strobe held longer than one fclk");

	rd_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		strobes.port_rd |=> !strobes.port_rd)
		else $error("port_rd strobe held longer than one fclk");

	rd_wr_apart: assert property (@(posedge fclk) disable iff (!rst_n)
		!(strobes.port_wr && strobes.port_rd))
		else $error("read and write strobes high together");

	////////////////////
	// no data drive onto an AY access
	dataout_not_ext: assert property (@(posedge fclk) disable iff (!rst_n)
		$rose(dataout) |-> !external_port)
		else $error("dataout rose during an external port access");

	palwr_in_io: assert property (@(posedge fclk) disable iff (!rst_n)
		$rose(up_palwr) |-> !iorq_n)
		else $error("palette write outside an io cycle");

endmodule

bind zports_top zports_checker u_checker (
	.fclk          (fclk),
	.rst_n         (rst_n),
	.strobes       (strobes),
	.dataout       (dataout),
	.external_port (external_port),
	.up_palwr      (up_palwr),
	.iorq_n        (bus.iorq_n)
);

// File: verification/zports_tb.sv
// testbench for the Z80 io port block
// LFSR driven io cycles checked against a register model

`include "zports_consts.svh"

module zports_tb import zports_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_PAGE         = 70;
	localparam int N_CFG          = 80;
	localparam int N_UP           = 80;
	localparam int N_FE           = 60;
	localparam int MAX_IO         = 300;             // io cycles, upper bound
	localparam int TIMEOUT_CYCLES = MAX_IO * 12 + 200; // 12 fclk per io cycle

	// dut inputs
	logic        fclk, rst_n, zpos;
	zbus_t       bus;
	logic        dos, tape_read;
	logic [4:0]  keys_in;

	// dut outputs
	logic [7:0]  dout, p7ffd, peff7, up_paldata;
	logic        dataout, porthit, external_port, ay_bc1, ay_bdir;
	logic [3:0]  border;
	logic        beeper_wr, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic [5:0]  pent1m_page, up_paladdr;
	logic        romrw_en, set_nmi, brk_ena, clr_nmi, up_ena, up_palwr;
	logic [15:0] brk_addr;

	////////////////////
	// register model
	logic [7:0]  m_p7ffd, m_peff7;
	logic [3:0]  m_border;
	logic        m_shadow_en, m_romrw, m_set_nmi, m_brk_ena;
	logic [15:0] m_brk;      // no reset in hw
	logic        m_up_sel, m_up_ena;
	logic [5:0]  m_paladdr;
	int          exp_beeper = 0, exp_clrnmi = 0, exp_palwr = 0;
	int          cnt_beeper = 0, cnt_clrnmi = 0, cnt_palwr = 0; // seen pulses

	logic [31:0] lfsr;
	string       test_name;
	int          err_count = 0;
	int          cycle_count = 0;

	zports_top u_zports_top (.*);

	////////////////////
	always #10 fclk = ~fclk; // 20 ns

	always @(posedge fclk)
		zpos <= ~zpos; // z80 clock at half fclk

	// run limit
	always @(posedge fclk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("error: timeout, run still going after %0d fclk cycles", cycle_count);
			$display("TEST FAIL");
			$fatal(1, "run limit reached");
		end
	end

	////////////////////
	// random source
	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = step_lfsr(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// G3R3B2 in, R3G3B2 out
	function automatic logic [7:0] grb_to_rgb(input logic [7:0] c);
		return {c[4:2], c[7:5], c[1:0]};
	endfunction

	task automatic report_error(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		err_count++;
		$display("error: %s %s expected %h actual %h", test_name, what, exp, act);
		$display("TEST FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_value(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp) else report_error(what, exp, act);
	endtask

	// pulse counters, palette data checked while the write is high
	always @(posedge fclk)
	begin
		if (beeper_wr)
			cnt_beeper++;
		if (clr_nmi)
			cnt_clrnmi++;
		if (up_palwr)
		begin
			cnt_palwr++;
			assert (up_paldata === grb_to_rgb(bus.din))
				else report_error("up_paldata", grb_to_rgb(bus.din), up_paldata);
		end
	end

	////////////////////
	// model rules
	function automatic logic port_is_hit(input logic [7:0] lo, input logic shadow);
		case (lo)
			`ZPORT_FE, `ZPORT_F6, `ZPORT_FD, `ZPORT_BF: return 1'b1;
			`ZPORT_BE, `ZPORT_BD, `ZPORT_ULAPLUS:        return 1'b1;
			`ZPORT_F7:                                   return !shadow;
			default:                                     return 1'b0;
		endcase
	endfunction

	function automatic logic [7:0] expected_read(input logic [15:0] addr);
		case (addr[7:0])
			`ZPORT_FE, `ZPORT_F6:
				return {1'b1, tape_read, 1'b0, keys_in};
			`ZPORT_BF:
				return {3'b000, m_brk_ena, m_set_nmi, 1'b0, m_romrw, m_shadow_en};
			`ZPORT_BE:
				case (addr[12:8])
					`BE_IDX_P7FFD: return m_p7ffd; // raw values
					`BE_IDX_PEFF7: return m_peff7;
					`BE_IDX_BRKLO: return m_brk[7:0];
					`BE_IDX_BRKHI: return m_brk[15:8];
					default:       return 8'hFF;
				endcase
			default:
				return 8'hFF;
		endcase
	endfunction

	task automatic apply_write(input logic [15:0] addr, input logic [7:0] data,
		input logic dos_val);
		logic [7:0] lo;
		logic       shadow;
		lo = addr[7:0];
		shadow = dos_val | m_shadow_en;
		if (lo == `ZPORT_FE || lo == `ZPORT_F6)
		begin
			m_border = {~addr[3], data[2:0]};
			exp_beeper++;
		end
		// 7FFD locked only with 1M blocked
		if (lo == `ZPORT_FD && !addr[15]
			&& !(m_p7ffd[`P7FFD_LOCK] && m_peff7[`EFF7_BLOCK1M]))
			m_p7ffd = data;
		if (lo == `ZPORT_F7 && !shadow && addr[8] && !addr[12])
			m_peff7 = data;
		if (lo == `ZPORT_BF)
		begin
			m_shadow_en = data[0];
			m_romrw     = data[1];
			m_set_nmi   = data[3];
			m_brk_ena   = data[4];
		end
		if (lo == `ZPORT_BD)
		begin
			if (addr[8])
				m_brk[15:8] = data;
			else
				m_brk[7:0] = data;
		end
		if (lo == `ZPORT_BE)
			exp_clrnmi++; // nmi end
		if (lo == `ZPORT_ULAPLUS)
		begin
			if (!addr[14])
			begin
				if (data[7:6] == `UP_MODE_GRP)
					m_up_sel = 1'b1;
				else if (data[7:6] == `UP_MODE_PAL)
				begin
					m_up_sel  = 1'b0;
					m_paladdr = data[5:0];
				end
			end
			else if (m_up_sel)
				m_up_ena = data[0];
			else
				exp_palwr++;
		end
	endtask

	// registers and idle outputs against the model
	task automatic check_state();
		logic block;
		block = m_peff7[`EFF7_BLOCK1M];
		check_value("p7ffd", block ? (m_p7ffd & 8'h1F) : m_p7ffd, p7ffd);
		check_value("peff7", block ? (m_peff7 & 8'hB1) : m_peff7, peff7);
		check_value("pent1m_page", {m_p7ffd[7:5], m_p7ffd[2:0]}, pent1m_page);
		check_value("pent1m_rom", m_p7ffd[4], pent1m_rom);
		check_value("pent1m_1m_on", !block, pent1m_1m_on);
		check_value("pent1m_ram0_0", m_peff7[3], pent1m_ram0_0);
		check_value("border", m_border, border);
		check_value("romrw_en", m_romrw, romrw_en);
		check_value("set_nmi", m_set_nmi, set_nmi);
		check_value("brk_ena", m_brk_ena, brk_ena);
		check_value("brk_addr", m_brk, brk_addr);
		check_value("up_ena", m_up_ena, up_ena);
		check_value("up_paladdr", m_paladdr, up_paladdr);
		check_value("beeper pulses", exp_beeper, cnt_beeper);
		check_value("clr_nmi pulses", exp_clrnmi, cnt_clrnmi);
		check_value("up_palwr pulses", exp_palwr, cnt_palwr);
		check_value("idle beeper_wr", 0, beeper_wr);
		check_value("idle clr_nmi", 0, clr_nmi);
		check_value("idle up_palwr", 0, up_palwr);
		check_value("idle dataout", 0, dataout);
		check_value("idle ay_bc1", 0, ay_bc1);
		check_value("idle ay_bdir", 0, ay_bdir);
	endtask

	////////////////////
	// one io cycle, 8 fclk active then 4 idle
	task automatic run_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic is_wr, input logic dos_val);
		logic fd, ext, hit;
		@(posedge fclk);
		dos       <= dos_val;
		keys_in   <= 5'(rand_bits(5));
		tape_read <= 1'(rand_bits(1));
		bus.a     <= addr;
		bus.din   <= data;
		bus.iorq_n <= 1'b0;
		bus.rd_n  <= is_wr;
		bus.wr_n  <= !is_wr;
		if (is_wr)
			apply_write(addr, data, dos_val);
		repeat (4) @(posedge fclk);
		@(negedge fclk); // mid cycle, bus stable
		fd  = (addr[7:0] == `ZPORT_FD);
		ext = fd & addr[15]; // AY ports
		hit = port_is_hit(addr[7:0], dos | m_shadow_en);
		check_value("external_port", ext, external_port);
		check_value("porthit", hit, porthit);
		check_value("ay_bc1", ext & addr[14], ay_bc1);
		check_value("ay_bdir", ext & is_wr, ay_bdir);
		check_value("dataout", !is_wr & hit & !ext, dataout);
		if (!is_wr)
			check_value("dout", expected_read(addr), dout);
		repeat (4) @(posedge fclk);
		bus.iorq_n <= 1'b1;
		bus.rd_n   <= 1'b1;
		bus.wr_n   <= 1'b1;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		check_state();
	endtask

	////////////////////
	initial
	begin
		logic [2:0] choice;
		logic [7:0] hi, d, lo;
		logic [4:0] idx;
		logic       dv;

		fclk       = 1'b0;
		rst_n      = 1'b0;
		zpos       = 1'b0;
		bus        = '0;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		dos        = 1'b0;
		keys_in    = '0;
		tape_read  = 1'b0;
		lfsr       = 32'h6664;

		m_p7ffd     = `P7FFD_RST;
		m_peff7     = `PEFF7_RST;
		m_border    = `BORDER_RST;
		m_shadow_en = 1'b0;
		m_romrw     = 1'b0;
		m_set_nmi   = 1'b0;
		m_brk_ena   = 1'b0;
		m_brk       = 'x;
		m_up_sel    = 1'b0;
		m_up_ena    = 1'b0;
		m_paladdr   = 'x;

		// test 1, reset state
		test_name = "reset";
		repeat (3) @(posedge fclk);
		rst_n <= 1'b1;
		@(negedge fclk);
		check_state();
		check_value("strobes", 0, u_zports_top.strobes);
		check_value("selects", 0, u_zports_top.sel);

		// test 2, paging
		test_name = "paging";
		for (int i = 0; i < N_PAGE; i++)
		begin
			choice = 3'(rand_bits(3));
			hi     = 8'(rand_bits(8));
			d      = 8'(rand_bits(8));
			dv     = (rand_bits(2) == 0); // dos now and then
			if (choice < 4)
				run_cycle({hi, `ZPORT_FD}, d, 1'b1, dv);
			else if (choice < 7) // a[8] mostly set, a[12] mostly clear
				run_cycle({hi[7:5], hi[4] & hi[5], hi[3:1], hi[0] | hi[1], `ZPORT_F7},
					d, 1'b1, dv);
			else
				run_cycle({hi, `ZPORT_BF}, d, 1'b1, dv);
		end

		// test 3, config, breakpoint and BE readback
		test_name = "config";
		run_cycle({8'h00, `ZPORT_BD}, 8'(rand_bits(8)), 1'b1, 1'b0);
		run_cycle({8'h01, `ZPORT_BD}, 8'(rand_bits(8)), 1'b1, 1'b0);
		for (int i = 0; i < N_CFG; i++)
		begin
			choice = 3'(rand_bits(3));
			hi     = 8'(rand_bits(8));
			d      = 8'(rand_bits(8));
			dv     = 1'(rand_bits(1));
			case (choice)
				3'd0: run_cycle({hi, `ZPORT_BF}, d, 1'b1, dv);
				3'd1: run_cycle({hi, `ZPORT_BD}, d, 1'b1, dv);
				3'd2: run_cycle({hi, `ZPORT_BE}, d, 1'b1, dv);
				default:
				begin
					case (3'(rand_bits(3)))
						3'd0:    idx = `BE_IDX_P7FFD;
						3'd1:    idx = `BE_IDX_PEFF7;
						3'd2:    idx = `BE_IDX_BRKLO;
						3'd3:    idx = `BE_IDX_BRKHI;
						3'd4:    idx = 5'(rand_bits(5)); // mostly unused indexes
						default: idx = 5'h1F;
					endcase
					if (idx == 5'h1F)
						run_cycle({hi, `ZPORT_BF}, d, 1'b0, dv);
					else
						run_cycle({hi[7:5], idx, `ZPORT_BE}, d, 1'b0, dv);
				end
			endcase
		end

		// test 4, ulaplus
		test_name = "ulaplus";
		run_cycle({8'hBF, `ZPORT_ULAPLUS}, {`UP_MODE_PAL, 6'(rand_bits(6))}, 1'b1, 1'b0);
		for (int i = 0; i < N_UP; i++)
		begin
			choice = 3'(rand_bits(2));
			hi     = 8'(rand_bits(8));
			d      = 8'(rand_bits(8));
			case (choice)
				3'd0: run_cycle({hi[7], 1'b0, hi[5:0], `ZPORT_ULAPLUS}, d, 1'b1, 1'b0);
				3'd1: run_cycle({hi[7], 1'b0, hi[5:0], `ZPORT_ULAPLUS},
					{`UP_MODE_GRP, d[5:0]}, 1'b1, 1'b0);
				default: run_cycle({hi[7], 1'b1, hi[5:0], `ZPORT_ULAPLUS}, d, 1'b1, 1'b0);
			endcase
		end

		// test 5, FE port and AY control
		test_name = "fe_ay";
		for (int i = 0; i < N_FE; i++)
		begin
			choice = 3'(rand_bits(2));
			hi     = 8'(rand_bits(8));
			d      = 8'(rand_bits(8));
			lo     = rand_bits(1) ? `ZPORT_FE : `ZPORT_F6;
			case (choice)
				3'd0:    run_cycle({hi, lo}, d, 1'b1, 1'b0);
				3'd1:    run_cycle({hi, lo}, d, 1'b0, 1'b0);
				3'd2:    run_cycle({hi, `ZPORT_FD}, d, 1'b1, 1'b0);
				default: run_cycle({hi, `ZPORT_FD}, d, 1'b0, 1'b0);
			endcase
		end

		if (err_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
